/* hw/cps2_bus_params.svh */
// ------------------------------
// cps2 main bus parameters
// region patterns, I/O offsets and wait-state limits
// ------------------------------
`ifndef CPS2_BUS_PARAMS_SVH
`define CPS2_BUS_PARAMS_SVH

// region patterns on the high address bits
`define ROM_HI      2'b00
`define RAM_HI      8'hFF
`define VRAM_HI     6'b100100
`define VRAM_SKIP   2'b11
`define ORAM_HI     8'h70
`define IO_HI       5'b10000
`define QS_HI       4'h6
`define QS_MID      3'd0

// work RAM folds down to this many word address bits
`define RAM_AW      15

// I/O offsets on address bits 8:3
`define IO_IN0      6'd0
`define IO_IN1      6'd1
`define IO_IN2      6'd2
`define IO_VOL      6'd6
`define IO_OUT      6'd8

// graphics chips on address bits 8:6
`define IO_PPU1     3'd4
`define IO_PPU2     3'd5

// nominal wait in cen strobes, and delay counter limit
`define WAIT_CYC    3
`define FAIL_MAX    4'd15

`endif

/* hw/cps2_bus_pkg.sv */
// ------------------------------
// cps2 main bus types
// CPU bus, select and cabinet structs
// ------------------------------
package cps2_bus_pkg;

    // CPU pins of one bus cycle
    typedef struct packed {
        logic [23:1] addr;
        logic        as_n;
        logic        rnw;
        logic        uds_n;
        logic        lds_n;
        logic [2:0]  fc;
        logic [15:0] dout;
    } cpu_bus_t;

    // memory region selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic oram;
        logic qs;
        logic io;
    } mem_sel_t;

    // selects inside the I/O window
    typedef struct packed {
        logic ppu1;
        logic ppu2;
        logic in0;
        logic in1;
        logic in2;
        logic vol;
        logic out;
        logic eeprom;
    } io_sel_t;

    // upper byte of the output word drives the EEPROM pins
    typedef struct packed {
        logic        rsv_hi;
        logic        scs;
        logic        sclk;
        logic        sdi;
        logic [11:0] rsv_lo;
    } eeprom_wr_t;

    // lower byte carries the sound CPU reset
    typedef struct packed {
        logic [11:0] rsv_hi;
        logic        z80_rstn;
        logic [2:0]  rsv_lo;
    } olatch_wr_t;

    typedef union packed {
        eeprom_wr_t eeprom;
        olatch_wr_t olatch;
    } io_wr_u;

    // cabinet controls, active low as on the harness
    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [9:0] joy3;
        logic [9:0] joy4;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       tilt;
        logic       dip_test;
    } cab_in_t;

endpackage

/* hw/cps2_addr_decode.sv */
// ------------------------------
// cps2 address decoder
// registers region selects at the start of each bus
// cycle and sub-decodes the I/O window
// ------------------------------
`timescale 1ns/10ps
`include "cps2_bus_params.svh"

module cps2_addr_decode import cps2_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    cpu,
    output mem_sel_t    mem,
    output io_sel_t     io,
    output logic [20:0] rom_addr,
    output logic [16:0] mem_addr
);

    logic [23:1] a;
    logic [5:0]  io_ofs;
    logic [2:0]  ppu_ofs;
    logic        wr_cyc;

    assign a       = cpu.addr;
    assign io_ofs  = a[8:3];
    assign ppu_ofs = a[8:6];
    assign wr_cyc  = !cpu.rnw;

    // region selects follow the address strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '0;
        end else if (!cpu.as_n) begin
            mem.rom  <= a[23:22] == `ROM_HI;
            mem.ram  <= a[23:16] == `RAM_HI;
            mem.vram <= a[23:18] == `VRAM_HI && a[17:16] != `VRAM_SKIP;
            mem.oram <= a[23:16] == `ORAM_HI;
            mem.qs   <= a[23:20] == `QS_HI && a[19:17] == `QS_MID;
            mem.io   <= a[23:19] == `IO_HI;
        end else begin
            mem <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!cpu.as_n) begin
            rom_addr <= a[21:1];
        end
    end

    // RAM and VRAM sit next to each other in SDRAM,
    // so work RAM is folded to keep them apart
    assign mem_addr = mem.ram ? {{(17 - `RAM_AW){1'b0}}, a[`RAM_AW:1]} : a[17:1];

    always_comb begin
        io = '0;
        if (mem.io) begin
            io.ppu1   = ppu_ofs == `IO_PPU1;
            io.ppu2   = ppu_ofs == `IO_PPU2;
            io.in0    = io_ofs == `IO_IN0;
            io.in1    = io_ofs == `IO_IN1;
            io.in2    = io_ofs == `IO_IN2;
            // QSound volume is write only
            io.vol    = io_ofs == `IO_VOL && wr_cyc;
            io.out    = io_ofs == `IO_OUT && wr_cyc && !cpu.lds_n;
            // upper byte reads back the EEPROM data pin
            io.eeprom = io_ofs == `IO_OUT && !cpu.uds_n;
        end
    end

endmodule

/* hw/cps2_bus_ctrl.sv */
// ------------------------------
// cps2 bus control
// DTACK wait states with delay recovery,
// plus the VBLANK interrupt level
// ------------------------------
`timescale 1ns/10ps
`include "cps2_bus_params.svh"

module cps2_bus_ctrl import cps2_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  cpu_bus_t cpu,
    input  mem_sel_t mem,
    input  logic     ram_ok,
    input  logic     rom_ok,
    input  logic     qs_waitn,
    input  logic     qs_busakn,
    input  logic     lvbl,
    output logic     dtack_n,
    output logic     ipl1_n
);

    logic [`WAIT_CYC-1:0] wait_sh;
    logic [3:0]           fail_cnt;
    logic                 fail_cnt_ok;
    logic                 late_seen;
    logic                 last_as_n;
    logic                 last_lvbl;
    logic                 busakn_meta;
    logic                 busakn_s;
    logic                 bus_cs;
    logic                 bus_busy;
    logic                 wait_done;
    logic                 wait_last;
    logic                 lvbl_fall;
    logic                 inta;

    assign bus_cs   = |{mem.rom, mem.ram, mem.vram, mem.oram, mem.qs};
    assign bus_busy = (mem.rom & ~rom_ok)
                    | ((mem.ram | mem.vram | mem.oram) & ~ram_ok)
                    | (mem.qs & ~qs_waitn);

    // shifter empties after WAIT_CYC strobes
    assign wait_done = !wait_sh[0];
    assign wait_last = wait_sh == {{(`WAIT_CYC-1){1'b0}}, 1'b1};

    assign lvbl_fall = last_lvbl && !lvbl;
    assign inta      = !cpu.as_n && cpu.fc == 3'b111;

    // Z80 bus grant comes from another clock domain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busakn_meta <= 1'b1;
            busakn_s    <= 1'b1;
        end else begin
            busakn_meta <= qs_busakn;
            busakn_s    <= busakn_meta;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n     <= 1'b1;
            wait_sh     <= '1;
            fail_cnt    <= '0;
            fail_cnt_ok <= 1'b0;
            late_seen   <= 1'b0;
            last_as_n   <= 1'b1;
        end else begin
            last_as_n <= cpu.as_n;
            // SDRAM is not trusted before the first ROM answer
            if (rom_ok) begin
                fail_cnt_ok <= 1'b1;
            end
            if (cpu.as_n || last_as_n || (mem.qs && busakn_s)) begin
                dtack_n   <= 1'b1;
                wait_sh   <= '1;
                late_seen <= 1'b0;
            end else begin
                if (cen) begin
                    wait_sh <= {1'b0, wait_sh[`WAIT_CYC-1:1]};
                end
                if (dtack_n) begin
                    if (!bus_cs) begin
                        dtack_n <= 1'b0;
                    end else if (!bus_busy &&
                                 (wait_done || (fail_cnt != '0 && wait_last))) begin
                        dtack_n <= 1'b0;
                        // one strobe won back
                        if (!wait_done) begin
                            fail_cnt <= fail_cnt - 4'd1;
                        end
                    end else if (wait_done && bus_busy && fail_cnt_ok && !late_seen) begin
                        late_seen <= 1'b1;
                        if (fail_cnt != `FAIL_MAX) begin
                            fail_cnt <= fail_cnt + 4'd1;
                        end
                    end
                end
            end
            // start each frame with a clean slate
            if (lvbl_fall) begin
                fail_cnt <= '0;
            end
        end
    end

    // VBLANK interrupt on level 2, cleared by the ack cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ipl1_n    <= 1'b1;
            last_lvbl <= 1'b0;
        end else begin
            last_lvbl <= lvbl;
            if (inta) begin
                ipl1_n <= 1'b1;
            end else if (lvbl_fall) begin
                ipl1_n <= 1'b0;
            end
        end
    end

endmodule

/* hw/cps2_io_regs.sv */
// ------------------------------
// cps2 I/O registers
// EEPROM pins, sound CPU reset and
// sampled cabinet input words
// ------------------------------
`timescale 1ns/10ps

module cps2_io_regs import cps2_bus_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  cpu_bus_t         cpu,
    input  io_sel_t          io,
    input  cab_in_t          cab,
    output logic [2:0][15:0] in_word,
    output logic             eeprom_scs,
    output logic             eeprom_sclk,
    output logic             eeprom_sdi,
    output logic             z80_rstn
);

    io_wr_u wr_word;
    logic   eeprom_we;
    logic   olatch_we;

    // same data word, read two ways depending on the byte strobe
    assign wr_word   = cpu.dout;
    assign eeprom_we = io.eeprom && !cpu.rnw;
    assign olatch_we = io.out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_scs  <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_sdi  <= 1'b0;
        end else if (cen && eeprom_we) begin
            eeprom_scs  <= wr_word.eeprom.scs;
            eeprom_sclk <= wr_word.eeprom.sclk;
            eeprom_sdi  <= wr_word.eeprom.sdi;
        end
    end

    // sound CPU held in reset until the game releases it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z80_rstn <= 1'b0;
        end else if (cen && olatch_we) begin
            z80_rstn <= wr_word.olatch.z80_rstn;
        end
    end

    // cabinet words sampled every clock
    always_ff @(posedge clk) begin
        in_word[0] <= {cab.joy2[7:0], cab.joy1[7:0]};
        in_word[1] <= {cab.joy4[7:0], cab.joy3[7:0]};
        // system word also echoes the EEPROM data line
        in_word[2] <= {4'h0, cab.coin, cab.start, 2'b11, ~cab.dip_test, eeprom_sdi};
    end

endmodule

/* hw/cps2_rdata_mux.sv */
// ------------------------------
// cps2 read data mux
// priority select of the word the CPU reads
// ------------------------------
`timescale 1ns/10ps

module cps2_rdata_mux import cps2_bus_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  mem_sel_t         mem,
    input  io_sel_t          io,
    input  logic [2:0][15:0] in_word,
    input  logic [15:0]      ram_data,
    input  logic [15:0]      rom_data,
    input  logic [15:0]      mmr_dout,
    input  logic [7:0]       qs_din,
    input  logic             eeprom_sdo,
    output logic [15:0]      cpu_din
);

    logic [15:0] din_nx;

    always_comb begin
        if (io.in0) begin
            din_nx = in_word[0];
        end else if (io.in1) begin
            din_nx = in_word[1];
        end else if (io.in2) begin
            din_nx = in_word[2];
        end else if (mem.ram | mem.vram | mem.oram) begin
            // all three live in the same SDRAM bank
            din_nx = ram_data;
        end else if (mem.rom) begin
            din_nx = rom_data;
        end else if (io.ppu2) begin
            din_nx = mmr_dout;
        end else if (io.eeprom) begin
            din_nx = {{15{1'b1}}, eeprom_sdo};
        end else if (mem.qs) begin
            // QSound shared RAM is byte wide
            din_nx = {8'hFF, qs_din};
        end else begin
            // open bus
            din_nx = 16'hFFFF;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'hFFFF;
        end else begin
            cpu_din <= din_nx;
        end
    end

endmodule

/* hw/cps2_main_bus.sv */
// ------------------------------
// cps2 main bus glue
// decode, bus control, I/O and read data
// ------------------------------
`timescale 1ns/10ps

module cps2_main_bus import cps2_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    // CPU bus
    input  cpu_bus_t    cpu,
    output logic        dtack_n,
    output logic        ipl1_n,
    output logic [15:0] cpu_din,
    // video timing
    input  logic        lvbl,
    // cabinet
    input  cab_in_t     cab,
    // SDRAM
    output mem_sel_t    mem,
    output logic [20:0] rom_addr,
    output logic [16:0] mem_addr,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    // graphics chips
    output logic        ppu1_cs,
    output logic        ppu2_cs,
    input  logic [15:0] mmr_dout,
    // QSound
    input  logic [7:0]  qs_din,
    input  logic        qs_waitn,
    input  logic        qs_busakn,
    output logic        z80_rstn,
    // EEPROM
    input  logic        eeprom_sdo,
    output logic        eeprom_scs,
    output logic        eeprom_sclk,
    output logic        eeprom_sdi
);

    io_sel_t          io;
    logic [2:0][15:0] in_word;

    assign ppu1_cs = io.ppu1;
    assign ppu2_cs = io.ppu2;

    cps2_addr_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .cpu        (cpu),
        .mem        (mem),
        .io         (io),
        .rom_addr   (rom_addr),
        .mem_addr   (mem_addr)
    );

    cps2_bus_ctrl u_bus_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .cpu        (cpu),
        .mem        (mem),
        .ram_ok     (ram_ok),
        .rom_ok     (rom_ok),
        .qs_waitn   (qs_waitn),
        .qs_busakn  (qs_busakn),
        .lvbl       (lvbl),
        .dtack_n    (dtack_n),
        .ipl1_n     (ipl1_n)
    );

    cps2_io_regs u_io_regs (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .cpu         (cpu),
        .io          (io),
        .cab         (cab),
        .in_word     (in_word),
        .eeprom_scs  (eeprom_scs),
        .eeprom_sclk (eeprom_sclk),
        .eeprom_sdi  (eeprom_sdi),
        .z80_rstn    (z80_rstn)
    );

    cps2_rdata_mux u_rdata_mux (
        .clk        (clk),
        .rst        (rst),
        .mem        (mem),
        .io         (io),
        .in_word    (in_word),
        .ram_data   (ram_data),
        .rom_data   (rom_data),
        .mmr_dout   (mmr_dout),
        .qs_din     (qs_din),
        .eeprom_sdo (eeprom_sdo),
        .cpu_din    (cpu_din)
    );

endmodule

/* verif/cps2_bus_properties.sv */
// ------------------------------
// cps2 bus properties
// DTACK and region select rules
// ------------------------------
`timescale 1ns/10ps

module cps2_bus_properties import cps2_bus_pkg::*; (
    input logic     clk,
    input logic     rst,
    input cpu_bus_t cpu,
    input mem_sel_t mem,
    input logic     ram_ok,
    input logic     rom_ok,
    input logic     qs_waitn,
    input logic     dtack_n
);

    logic mem_busy;

    // selected region not ready yet
    assign mem_busy = (mem.rom & ~rom_ok)
                    | ((mem.ram | mem.vram | mem.oram) & ~ram_ok)
                    | (mem.qs & ~qs_waitn);

    a_dtack_idle: assert property (@(posedge clk) disable iff (rst)
        cpu.as_n && $past(cpu.as_n) |-> dtack_n)
        else $error("DTACK low while the address strobe is high");

    // regions never overlap
    a_one_sel: assert property (@(posedge clk) disable iff (rst) $onehot0(mem))
        else $error("more than one region selected");

    a_wait_ok: assert property (@(posedge clk) disable iff (rst)
        dtack_n && mem_busy |=> dtack_n)
        else $error("DTACK fell while the selected memory was not ready");

endmodule

bind cps2_bus_ctrl cps2_bus_properties props_inst (
    .clk      (clk),
    .rst      (rst),
    .cpu      (cpu),
    .mem      (mem),
    .ram_ok   (ram_ok),
    .rom_ok   (rom_ok),
    .qs_waitn (qs_waitn),
    .dtack_n  (dtack_n)
);

/* verif/cps2_main_bus_tb.sv */
// ------------------------------
// cps2 main bus testbench
// random bus cycles checked against
// a reference model of the glue logic
// ------------------------------
`timescale 1ns/10ps
`include "cps2_bus_params.svh"

module cps2_main_bus_tb import cps2_bus_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int N_RAND       = 150;
    localparam int N_IO         = 40;
    localparam int N_WR         = 40;
    localparam int N_STALL      = 4;
    localparam int STALL_DLY    = 24;
    localparam int DTACK_LIMIT  = 16;
    localparam int CYC_CLKS     = STALL_DLY + DTACK_LIMIT + 4;
    localparam int N_CYC_TOTAL  = N_RAND + N_IO + N_WR + N_STALL + 8;
    localparam int WATCHDOG_NS  = (N_CYC_TOTAL * CYC_CLKS + 100) * CLK_PERIOD;

    logic             clk;
    logic             rst;
    logic             cen;
    cpu_bus_t         cpu;
    logic             dtack_n;
    logic             ipl1_n;
    logic [15:0]      cpu_din;
    logic             lvbl;
    cab_in_t          cab;
    mem_sel_t         mem;
    logic [20:0]      rom_addr;
    logic [16:0]      mem_addr;
    logic [15:0]      ram_data;
    logic             ram_ok;
    logic [15:0]      rom_data;
    logic             rom_ok;
    logic             ppu1_cs;
    logic             ppu2_cs;
    logic [15:0]      mmr_dout;
    logic [7:0]       qs_din;
    logic             qs_waitn;
    logic             qs_busakn;
    logic             z80_rstn;
    logic             eeprom_sdo;
    logic             eeprom_scs;
    logic             eeprom_sclk;
    logic             eeprom_sdi;

    logic [31:0]      seed;
    int               n_checks;
    int               n_errors;
    int               test_err0;
    // model state
    logic             m_scs;
    logic             m_sclk;
    logic             m_sdi;
    logic             m_z80;
    logic             m_ipl;

    cps2_main_bus cps2_main_bus_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        cen <= ~cen;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            seed = lfsr_next(seed);
            v = {v[30:0], seed[0]};
        end
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        n_checks++;
        if (exp !== got) begin
            n_errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_error(input string msg);
        n_errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, n_errors - test_err0);
        test_err0 = n_errors;
    endtask

    function automatic mem_sel_t exp_mem(input logic [23:1] a);
        mem_sel_t m;
        m      = '0;
        m.rom  = a[23:22] == `ROM_HI;
        m.ram  = a[23:16] == `RAM_HI;
        m.vram = a[23:18] == `VRAM_HI && a[17:16] != `VRAM_SKIP;
        m.oram = a[23:16] == `ORAM_HI;
        m.qs   = a[23:20] == `QS_HI && a[19:17] == `QS_MID;
        m.io   = a[23:19] == `IO_HI;
        return m;
    endfunction

    // read word by source priority
    function automatic logic [15:0] exp_rdata(input logic [23:1] a, input logic uds_n);
        mem_sel_t m;
        logic [5:0] ofs;
        m   = exp_mem(a);
        ofs = a[8:3];
        if (m.io && ofs == `IO_IN0) begin
            return {cab.joy2[7:0], cab.joy1[7:0]};
        end else if (m.io && ofs == `IO_IN1) begin
            return {cab.joy4[7:0], cab.joy3[7:0]};
        end else if (m.io && ofs == `IO_IN2) begin
            return {4'h0, cab.coin, cab.start, 2'b11, ~cab.dip_test, m_sdi};
        end else if (m.ram || m.vram || m.oram) begin
            return ram_data;
        end else if (m.rom) begin
            return rom_data;
        end else if (m.io && a[8:6] == `IO_PPU2) begin
            return mmr_dout;
        end else if (m.io && ofs == `IO_OUT && !uds_n) begin
            return {15'h7FFF, eeprom_sdo};
        end else if (m.qs) begin
            return {8'hFF, qs_din};
        end
        return 16'hFFFF;
    endfunction

    // region < 0 picks one at random
    task automatic make_addr(input int region, output logic [23:1] a);
        logic [31:0] r;
        logic [2:0]  reg_sel;
        logic [2:0]  ofs_sel;
        logic [5:0]  ofs;
        rand_bits(23, r);
        a = r[22:0];
        rand_bits(6, r);
        reg_sel = (region < 0) ? r[2:0] : region[2:0];
        ofs_sel = r[5:3];
        rand_bits(3, r);
        case (ofs_sel)
            3'd0: ofs = `IO_IN0;
            3'd1: ofs = `IO_IN1;
            3'd2: ofs = `IO_IN2;
            3'd3: ofs = `IO_VOL;
            3'd4: ofs = `IO_OUT;
            3'd5: ofs = {`IO_PPU1, r[2:0]};
            3'd6: ofs = {`IO_PPU2, r[2:0]};
            default: ofs = a[8:3];
        endcase
        case (reg_sel)
            3'd0: a[23:22] = `ROM_HI;
            3'd1: a[23:16] = `RAM_HI;
            3'd2: a[23:18] = `VRAM_HI;
            3'd3: a[23:16] = `ORAM_HI;
            3'd4: begin
                a[23:19] = `IO_HI;
                a[8:3]   = ofs;
            end
            3'd5: begin
                a[23:20] = `QS_HI;
                a[19:17] = `QS_MID;
            end
            default: ;
        endcase
    endtask

    task automatic bus_cycle(input logic [23:1] a, input logic rnw, input logic [1:0] strb_n,
                             input logic [2:0] f, input logic [15:0] d, input int dly);
        mem_sel_t    em;
        logic [15:0] exp_word;
        logic [16:0] exp_maddr;
        logic [31:0] r;
        logic [31:0] r2;
        logic        is_mem;
        logic        done;
        int          n;
        @(negedge clk);
        // source data held for the whole cycle
        rand_bits(32, r);
        ram_data = r[15:0];
        rom_data = r[31:16];
        rand_bits(25, r);
        mmr_dout   = r[15:0];
        qs_din     = r[23:16];
        eeprom_sdo = r[24];
        rand_bits(32, r);
        rand_bits(19, r2);
        cab = {r2[18:0], r};
        em        = exp_mem(a);
        exp_word  = exp_rdata(a, strb_n[1]);
        exp_maddr = a[17:1];
        // work RAM keeps only its low word address bits
        if (em.ram) begin
            exp_maddr[16:`RAM_AW] = '0;
        end
        is_mem    = em.rom | em.ram | em.vram | em.oram | em.qs;
        ram_ok    = (dly == 0);
        rom_ok    = (dly == 0);
        qs_waitn  = (dly == 0);
        cpu.addr  = a;
        cpu.rnw   = rnw;
        cpu.uds_n = strb_n[1];
        cpu.lds_n = strb_n[0];
        cpu.fc    = f;
        cpu.dout  = d;
        cpu.as_n  = 1'b0;
        n    = 0;
        done = 1'b0;
        while (!done && n < dly + DTACK_LIMIT) begin
            @(negedge clk);
            n++;
            if (!dtack_n) begin
                done = 1'b1;
                if (is_mem && !ram_ok) begin
                    report_error("DTACK asserted while the memory ok signal was low");
                end
            end else if (n >= dly) begin
                ram_ok   = 1'b1;
                rom_ok   = 1'b1;
                qs_waitn = 1'b1;
            end
        end
        if (!done) begin
            report_error($sformatf("no DTACK within %0d clocks at address %h", n, {a, 1'b0}));
        end else begin
            compare("mem", em, mem);
            compare("rom_addr", a[21:1], rom_addr);
            compare("mem_addr", exp_maddr, mem_addr);
            compare("ppu1_cs", em.io && a[8:6] == `IO_PPU1, ppu1_cs);
            compare("ppu2_cs", em.io && a[8:6] == `IO_PPU2, ppu2_cs);
            if (rnw) begin
                compare("cpu_din", exp_word, cpu_din);
            end
            if (!rnw && em.io && a[8:3] == `IO_OUT) begin
                if (!strb_n[1]) begin
                    {m_scs, m_sclk, m_sdi} = d[14:12];
                end
                if (!strb_n[0]) begin
                    m_z80 = d[3];
                end
            end
            if (f == 3'b111) begin
                m_ipl = 1'b1;
            end
        end
        cpu.as_n = 1'b1;
        @(negedge clk);
        compare("dtack_n", 1, dtack_n);
        compare("eeprom_scs", m_scs, eeprom_scs);
        compare("eeprom_sclk", m_sclk, eeprom_sclk);
        compare("eeprom_sdi", m_sdi, eeprom_sdi);
        compare("z80_rstn", m_z80, z80_rstn);
        compare("ipl1_n", m_ipl, ipl1_n);
    endtask

    // rw selects 0 write, 1 read or 2 either
    task automatic random_cycle(input int region, input int rw);
        logic [23:1] a;
        logic [31:0] r;
        logic        rnw;
        logic [1:0]  strb_n;
        make_addr(region, a);
        rand_bits(24, r);
        rnw    = (rw == 2) ? r[0] : rw[0];
        strb_n = (r[2:1] == 2'b11) ? 2'b00 : r[2:1];
        bus_cycle(a, rnw, strb_n, 3'b101, r[23:8], r[6:4]);
    endtask

    initial begin
        logic [23:1] a;
        logic [31:0] r;
        logic [1:0]  strb_n;
        seed       = 32'h24ba;
        n_checks   = 0;
        n_errors   = 0;
        test_err0  = 0;
        rst        = 1'b1;
        cen        = 1'b0;
        cpu        = '0;
        cpu.as_n   = 1'b1;
        cpu.rnw    = 1'b1;
        cpu.uds_n  = 1'b1;
        cpu.lds_n  = 1'b1;
        lvbl       = 1'b1;
        cab        = '1;
        ram_data   = '0;
        ram_ok     = 1'b1;
        rom_data   = '0;
        rom_ok     = 1'b1;
        mmr_dout   = '0;
        qs_din     = '0;
        qs_waitn   = 1'b1;
        qs_busakn  = 1'b0;
        eeprom_sdo = 1'b0;
        {m_scs, m_sclk, m_sdi} = 3'b000;
        m_z80 = 1'b0;
        m_ipl = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare("dtack_n", 1, dtack_n);
        compare("ipl1_n", 1, ipl1_n);
        compare("mem", 0, mem);
        compare("z80_rstn", 0, z80_rstn);
        compare("eeprom pins", 0, {eeprom_scs, eeprom_sclk, eeprom_sdi});
        end_test("reset");

        repeat (N_RAND) random_cycle(-1, 2);
        end_test("random_decode");

        repeat (N_IO) random_cycle(4, 1);
        end_test("io_reads");

        // output word written through upper only, lower only or both strobes
        repeat (N_WR) begin
            make_addr(4, a);
            a[8:3] = `IO_OUT;
            rand_bits(18, r);
            strb_n = (r[1:0] == 2'd0) ? 2'b01 : (r[1:0] == 2'd1) ? 2'b10 : 2'b00;
            bus_cycle(a, 1'b0, strb_n, 3'b101, r[17:2], r[4:2]);
        end
        end_test("out_writes");

        // ok held low for a long stretch
        for (int i = 0; i < N_STALL; i++) begin
            make_addr(i % 2, a);
            bus_cycle(a, 1'b1, 2'b00, 3'b101, 16'h0000, STALL_DLY);
        end
        end_test("stall");

        @(negedge clk);
        lvbl = 1'b0;
        @(negedge clk);
        m_ipl = 1'b0;
        compare("ipl1_n", 0, ipl1_n);
        repeat (4) random_cycle(-1, 1);
        make_addr(-1, a);
        bus_cycle(a, 1'b1, 2'b00, 3'b111, 16'h0000, 0);
        lvbl = 1'b1;
        end_test("vblank_irq");

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
hw/cps2_bus_pkg.sv
hw/cps2_addr_decode.sv
hw/cps2_bus_ctrl.sv
hw/cps2_io_regs.sv
hw/cps2_rdata_mux.sv
hw/cps2_main_bus.sv
verif/cps2_bus_properties.sv
verif/cps2_main_bus_tb.sv
